// ==== lsu_pkg.sv ====
package lsu_pkg;

    // ========================================
    // Widths and sizes
    // ========================================

    // A data word and a byte address share the same 32-bit width
    typedef logic [31:0] data_word_t;

    // Number of entries in the store buffer by default
    // The buffer indexes entries with wrapping pointers, so this must be a power of two
    localparam int unsigned DEFAULT_SB_DEPTH = 4;

    // ========================================
    // Store width encoding
    // ========================================

    // Size of the access carried by a store request
    typedef enum logic [1:0] {
        STORE_BYTE = 2'b00,
        STORE_HALF = 2'b01,
        STORE_WORD = 2'b10
    } store_width_t;

    // ========================================
    // Data and entry formats
    // ========================================

    // The same 32 bits seen either as one word or as four byte lanes
    // Lane 0 holds the byte at the lowest address of the word
    typedef union packed {
        data_word_t      word;
        logic [3:0][7:0] bytes;
    } store_data_u;

    // A store as it arrives from the execution unit
    // The data sits in the low bits for byte and half accesses
    typedef struct packed {
        data_word_t   address;
        data_word_t   data;
        store_width_t width;
    } store_req_t;

    // A formatted store with its data already placed in the addressed lanes
    // This is also the content of one store buffer entry
    typedef struct packed {
        logic [29:0] word_addr;
        store_data_u data;
        logic [3:0]  strobe;
    } store_entry_t;

    // One write toward memory
    // The address is word aligned and the strobe selects the bytes written
    typedef struct packed {
        data_word_t address;
        data_word_t data;
        logic [3:0] strobe;
    } mem_write_t;

endpackage : lsu_pkg

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the store path testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module store_path_tb -f sources.f \
    --Mdir obj_dir -o store_path_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/store_path_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$SIM_LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== sources.f ====
lsu_pkg.sv
store_format.sv
store_buffer.sv
store_drain.sv
store_path_top.sv
tb_clock_gen.sv
store_path_tb.sv

// ==== store_buffer.sv ====
`timescale 1ns/10ps

module store_buffer import lsu_pkg::*; #(
    parameter int unsigned SB_DEPTH = DEFAULT_SB_DEPTH
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         push_i,
    input  store_entry_t entry_i,
    input  logic         commit_i,
    input  logic         pop_i,
    output logic         full_o,
    output logic         head_valid_o,
    output store_entry_t head_entry_o,
    input  data_word_t   fwd_addr_i,
    output logic         fwd_hit_o,
    output data_word_t   fwd_data_o,
    output logic [3:0]   fwd_strobe_o
);

    // Pointer width and a counter one bit wider so that a full buffer is representable
    localparam int unsigned PTR_W = $clog2(SB_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    localparam logic [CNT_W-1:0] CNT_FULL   = CNT_W'(SB_DEPTH);
    localparam logic [CNT_W-1:0] CNT_ALMOST = CNT_W'(SB_DEPTH - 1);

    // Entry storage, a plain register array without reset
    store_entry_t sb_mem [SB_DEPTH];

    // Pointers walk the ring in the order pop, commit, push
    logic [PTR_W-1:0] push_ptr;
    logic [PTR_W-1:0] commit_ptr;
    logic [PTR_W-1:0] pop_ptr;

    // All live entries, the committed part of them and the rest
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] cmt_count;
    logic [CNT_W-1:0] uncmt_count;

    logic             merge_hit;
    logic [PTR_W-1:0] merge_idx;
    logic             alloc;
    logic             merge_fire;
    logic             commit_fire;
    logic             pop_fire;

    // ========================================
    // Merge search
    // ========================================

    // Scans the uncommitted entries from oldest to youngest
    // The last match found is the youngest one and becomes the merge target
    always_comb begin : merge_search
        logic [PTR_W-1:0] scan_idx;

        merge_hit = 1'b0;
        merge_idx = push_ptr;

        for (int k = 0; k < SB_DEPTH; k++) begin
            scan_idx = commit_ptr + PTR_W'(k);

            if ((CNT_W'(k) < uncmt_count) && (sb_mem[scan_idx].word_addr == entry_i.word_addr)) begin
                merge_hit = 1'b1;
                merge_idx = scan_idx;
            end
        end
    end : merge_search

    // ========================================
    // Pointer and counter control
    // ========================================

    assign uncmt_count = count - cmt_count;

    // A flush beats a push, so neither a merge nor an allocation happens then
    assign merge_fire = push_i && !flush_i && merge_hit;
    assign alloc      = push_i && !flush_i && !merge_hit && (count != CNT_FULL);

    // A commit may land on the entry allocated in the same cycle
    assign commit_fire = commit_i && ((uncmt_count != '0) || alloc);

    // Only a committed head can leave the buffer
    assign pop_fire = pop_i && (cmt_count != '0);

    always_ff @(posedge clk_i) begin : control_register
        if (!rst_n_i) begin
            push_ptr   <= '0;
            commit_ptr <= '0;
            pop_ptr    <= '0;
            count      <= '0;
            cmt_count  <= '0;
        end else begin
            commit_ptr <= commit_ptr + PTR_W'(commit_fire);
            pop_ptr    <= pop_ptr + PTR_W'(pop_fire);
            cmt_count  <= cmt_count + CNT_W'(commit_fire) - CNT_W'(pop_fire);

            if (flush_i) begin
                // Everything past the commit pointer is dropped
                push_ptr <= commit_ptr + PTR_W'(commit_fire);
                count    <= cmt_count + CNT_W'(commit_fire) - CNT_W'(pop_fire);
            end else begin
                push_ptr <= push_ptr + PTR_W'(alloc);
                count    <= count + CNT_W'(alloc) - CNT_W'(pop_fire);
            end
        end
    end : control_register

    // ========================================
    // Entry writes
    // ========================================

    // A new store fills the slot at the push pointer
    // A merged store overwrites only its strobed lanes and widens the strobe
    always_ff @(posedge clk_i) begin : entry_write
        if (alloc) begin
            sb_mem[push_ptr] <= entry_i;
        end else if (merge_fire) begin
            for (int b = 0; b < 4; b++) begin
                if (entry_i.strobe[b]) begin
                    sb_mem[merge_idx].data.bytes[b] <= entry_i.data.bytes[b];
                end
            end

            sb_mem[merge_idx].strobe <= sb_mem[merge_idx].strobe | entry_i.strobe;
        end
    end : entry_write

    // ========================================
    // Status and head
    // ========================================

    // The stage before holds one more store, so full also rises when that store
    // would take the last free slot
    assign full_o = (count == CNT_FULL) || ((count == CNT_ALMOST) && push_i);

    assign head_valid_o = (cmt_count != '0);
    assign head_entry_o = sb_mem[pop_ptr];

    // ========================================
    // Load forwarding
    // ========================================

    // Every live entry takes part, committed or not, and the youngest match wins
    always_comb begin : forward_search
        logic [PTR_W-1:0] scan_idx;

        fwd_hit_o    = 1'b0;
        fwd_data_o   = '0;
        fwd_strobe_o = '0;

        for (int k = 0; k < SB_DEPTH; k++) begin
            scan_idx = pop_ptr + PTR_W'(k);

            if ((CNT_W'(k) < count) && (sb_mem[scan_idx].word_addr == fwd_addr_i[31:2])) begin
                fwd_hit_o    = 1'b1;
                fwd_data_o   = sb_mem[scan_idx].data.word;
                fwd_strobe_o = sb_mem[scan_idx].strobe;
            end
        end
    end : forward_search

endmodule : store_buffer

// ==== store_drain.sv ====
`timescale 1ns/10ps

module store_drain import lsu_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         head_valid_i,
    input  store_entry_t head_entry_i,
    input  logic         mem_ack_i,
    output logic         pop_o,
    output logic         mem_req_o,
    output mem_write_t   mem_write_o
);

    // Start and end of one memory write
    logic       req_start;
    logic       req_done;

    // The head entry already in memory write format
    mem_write_t next_write;

    // ========================================
    // Request control
    // ========================================

    // A new request starts only while no request is open
    // In the acknowledge cycle the request is still open, so the popped head
    // is never requested twice
    assign req_start = !mem_req_o && head_valid_i;

    // An acknowledge outside of a request is ignored
    assign req_done = mem_req_o && mem_ack_i;

    // The buffer drops its head in the same cycle as the acknowledge
    assign pop_o = req_done;

    // The request level rises one edge after a committed head shows up
    // and falls at the acknowledge edge
    always_ff @(posedge clk_i) begin : request_register
        if (!rst_n_i) begin
            mem_req_o <= 1'b0;
        end else if (req_done) begin
            mem_req_o <= 1'b0;
        end else if (req_start) begin
            mem_req_o <= 1'b1;
        end
    end : request_register

    // ========================================
    // Write payload
    // ========================================

    // Rebuild the byte address from the word address
    always_comb begin : write_format
        next_write.address = {head_entry_i.word_addr, 2'b00};
        next_write.data    = head_entry_i.data.word;
        next_write.strobe  = head_entry_i.strobe;
    end : write_format

    // Captured once per request and held stable until the acknowledge
    always_ff @(posedge clk_i) begin : write_register
        if (req_start) begin
            mem_write_o <= next_write;
        end
    end : write_register

endmodule : store_drain

// ==== store_format.sv ====
`timescale 1ns/10ps

module store_format import lsu_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         store_valid_i,
    input  store_req_t   store_req_i,
    output logic         push_o,
    output store_entry_t entry_o
);

    // Data replicated into the lanes and the matching byte strobe
    store_data_u fmt_data;
    logic [3:0]  fmt_strobe;

    // ========================================
    // Lane placement and byte strobe
    // ========================================

    // Every lane receives a copy of the store data so that the strobe alone
    // decides which bytes reach memory
    // The low address bits only pick the strobe, misaligned stores never occur
    always_comb begin : lane_format
        fmt_data.word = store_req_i.data;
        fmt_strobe    = 4'b0000;

        case (store_req_i.width)
            STORE_BYTE: begin
                // The low byte goes into all four lanes
                for (int b = 0; b < 4; b++) begin
                    fmt_data.bytes[b] = store_req_i.data[7:0];
                end

                // One lane selected by both low address bits
                fmt_strobe = 4'b0001 << store_req_i.address[1:0];
            end

            STORE_HALF: begin
                // The low half goes into both half lanes
                fmt_data.bytes[0] = store_req_i.data[7:0];
                fmt_data.bytes[1] = store_req_i.data[15:8];
                fmt_data.bytes[2] = store_req_i.data[7:0];
                fmt_data.bytes[3] = store_req_i.data[15:8];

                // Address bit 1 picks the upper or lower half of the word
                if (store_req_i.address[1]) begin
                    fmt_strobe = 4'b1100;
                end else begin
                    fmt_strobe = 4'b0011;
                end
            end

            STORE_WORD: begin
                // The whole word is written as it is
                fmt_data.word = store_req_i.data;
                fmt_strobe    = 4'b1111;
            end

            default: begin
                // An unknown width writes no byte at all
                fmt_data.word = store_req_i.data;
                fmt_strobe    = 4'b0000;
            end
        endcase
    end : lane_format

    // ========================================
    // Stage register
    // ========================================

    // The push strobe is control state and is cleared by reset
    // A flush kills the store held here as well as one arriving in the same cycle
    always_ff @(posedge clk_i) begin : push_register
        if (!rst_n_i) begin
            push_o <= 1'b0;
        end else if (flush_i) begin
            push_o <= 1'b0;
        end else begin
            push_o <= store_valid_i;
        end
    end : push_register

    // Payload of the entry, loaded only when a store is accepted
    always_ff @(posedge clk_i) begin : entry_register
        if (store_valid_i) begin
            entry_o.word_addr <= store_req_i.address[31:2];
            entry_o.data      <= fmt_data;
            entry_o.strobe    <= fmt_strobe;
        end
    end : entry_register

endmodule : store_format

// ==== store_path_tb.sv ====
`timescale 1ns/10ps

module store_path_tb import lsu_pkg::*;;

    localparam int unsigned SB_DEPTH = DEFAULT_SB_DEPTH;
    localparam int unsigned TIMEOUT  = 500;

    logic       clk;
    logic       rst_n;
    logic       store_valid_i;
    store_req_t store_req_i;
    logic       store_full_o;
    logic       commit_i;
    logic       flush_i;
    data_word_t fwd_addr_i;
    logic       fwd_hit_o;
    data_word_t fwd_data_o;
    logic [3:0] fwd_strobe_o;
    logic       mem_req_o;
    mem_write_t mem_write_o;
    logic       mem_ack_i = 1'b0;

    // The oldest model entry sits at index 0 and the first n_cmt of them are committed
    store_entry_t model_q[$];
    int           n_cmt = 0;
    int unsigned  error_count = 0;
    int unsigned  write_count = 0;
    logic         ack_en = 1'b0;
    logic [31:0]  stim_lfsr = 32'd96525;
    logic [31:0]  ack_lfsr = 32'd96525;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clock (.clk_o(clk), .rst_n_o(rst_n));

    store_path_top #(.SB_DEPTH(SB_DEPTH)) dut0 (
        .clk_i (clk), .rst_n_i (rst_n), .store_valid_i (store_valid_i),
        .store_req_i (store_req_i), .store_full_o (store_full_o), .commit_i (commit_i),
        .flush_i (flush_i), .fwd_addr_i (fwd_addr_i), .fwd_hit_o (fwd_hit_o),
        .fwd_data_o (fwd_data_o), .fwd_strobe_o (fwd_strobe_o), .mem_req_o (mem_req_o),
        .mem_write_o (mem_write_o), .mem_ack_i (mem_ack_i)
    );

    // ========================================
    // Random numbers and reporting
    // ========================================

    // Galois LFSR with the taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // One LFSR step for every bit handed out
    function automatic logic [31:0] take_bits(int unsigned n);
        logic [31:0] value;
        value = '0;
        for (int unsigned i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            value = {value[30:0], stim_lfsr[0]};
        end
        return value;
    endfunction

    function automatic void flag_mismatch(string name, logic [31:0] got, logic [31:0] expected);
        error_count++;
        $display("ERROR %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
    endfunction

    task automatic end_run();
        $display("Store path run done: %0d memory writes, %0d errors", write_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    task automatic fail_run(string why);
        error_count++;
        $display("%s", why);
        end_run();
    endtask

    // ========================================
    // Reference model
    // ========================================

    // Byte and half data is copied into every lane and the strobe marks the written bytes
    function automatic store_entry_t expect_entry(store_req_t req);
        store_entry_t e;
        e.word_addr = req.address[31:2];
        case (req.width)
            STORE_BYTE: begin
                e.data.word = {4{req.data[7:0]}};
                e.strobe    = 4'b0001 << req.address[1:0];
            end
            STORE_HALF: begin
                e.data.word = {2{req.data[15:0]}};
                e.strobe    = req.address[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                e.data.word = req.data;
                e.strobe    = 4'b1111;
            end
        endcase
        return e;
    endfunction

    // Merges into the youngest uncommitted entry of the same word, or appends
    task automatic model_push(store_entry_t e);
        int           idx;
        store_entry_t old;
        idx = -1;
        for (int k = n_cmt; k < model_q.size(); k++) begin
            if (model_q[k].word_addr == e.word_addr) idx = k;
        end
        if (idx < 0) begin
            model_q.push_back(e);
        end else begin
            old = model_q[idx];
            // Only the newly strobed lanes are replaced
            for (int b = 0; b < 4; b++) begin
                if (e.strobe[b]) old.data.bytes[b] = e.data.bytes[b];
            end
            old.strobe   = old.strobe | e.strobe;
            model_q[idx] = old;
        end
    endtask

    // ========================================
    // Stimulus tasks that start and end on a falling edge
    // ========================================

    function automatic store_req_t make_req(data_word_t addr, data_word_t data, store_width_t w);
        store_req_t req;
        req.address = addr;
        req.data    = data;
        req.width   = w;
        return req;
    endfunction

    task automatic wait_not_full();
        int unsigned cycles;
        cycles = 0;
        while (store_full_o) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("Timeout waiting for the store buffer to accept a store");
            end
        end
    endtask

    // The store is pushed into the buffer by the time this returns
    task automatic do_store(store_req_t req);
        wait_not_full();
        store_valid_i = 1'b1;
        store_req_i   = req;
        model_push(expect_entry(req));
        @(negedge clk);
        store_valid_i = 1'b0;
        @(negedge clk);
    endtask

    // One commit marks the oldest uncommitted model entry as committed
    task automatic do_commit();
        commit_i = 1'b1;
        n_cmt++;
        @(negedge clk);
        commit_i = 1'b0;
    endtask

    // A store still in the format stage meets the flush and is dropped with the rest
    task automatic flush_with_store(store_req_t req);
        wait_not_full();
        store_valid_i = 1'b1;
        store_req_i   = req;
        @(negedge clk);
        store_valid_i = 1'b0;
        flush_i       = 1'b1;
        while (model_q.size() > n_cmt) void'(model_q.pop_back());
        @(negedge clk);
        flush_i = 1'b0;
    endtask

    // The youngest model entry of the word is the one the buffer must return
    task automatic check_forward(data_word_t addr);
        logic         hit;
        store_entry_t e;
        hit = 1'b0;
        e   = '0;
        fwd_addr_i = addr;
        for (int k = 0; k < model_q.size(); k++) begin
            if (model_q[k].word_addr == addr[31:2]) begin
                hit = 1'b1;
                e   = model_q[k];
            end
        end
        // Forwarding is combinational, so sample halfway through the low phase
        #5;
        assert (fwd_hit_o == hit)
            else flag_mismatch("fwd_hit_o", 32'(fwd_hit_o), 32'(hit));
        if (hit) begin
            assert (fwd_data_o == e.data.word)
                else flag_mismatch("fwd_data_o", fwd_data_o, e.data.word);
            assert (fwd_strobe_o == e.strobe)
                else flag_mismatch("fwd_strobe_o", 32'(fwd_strobe_o), 32'(e.strobe));
        end
        @(negedge clk);
    endtask

    // Drained means the model is empty and no memory write is still open
    task automatic wait_drained();
        int unsigned cycles;
        cycles = 0;
        while (model_q.size() != 0 || mem_req_o) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) fail_run("Timeout waiting for the store buffer to drain");
        end
    endtask

    // ========================================
    // Memory side
    // ========================================

    // Acknowledge after a random number of cycles while enabled
    always @(negedge clk) begin : ack_driver
        ack_lfsr <= lfsr_next(ack_lfsr);
        mem_ack_i <= ack_en && mem_req_o && !mem_ack_i && ack_lfsr[0];
    end : ack_driver

    // Every finished write must be the oldest committed store of the model
    always @(posedge clk) begin : write_monitor
        store_entry_t e;
        if (rst_n && mem_req_o && mem_ack_i) begin
            write_count++;
            assert (n_cmt > 0) else begin
                error_count++;
                $display("Memory write seen while the model holds no committed store");
            end
            if (n_cmt > 0) begin
                e = model_q.pop_front();
                n_cmt--;
                assert (mem_write_o.address == {e.word_addr, 2'b00})
                    else flag_mismatch("mem_write_o.address", mem_write_o.address,
                                       {e.word_addr, 2'b00});
                assert (mem_write_o.data == e.data.word)
                    else flag_mismatch("mem_write_o.data", mem_write_o.data, e.data.word);
                assert (mem_write_o.strobe == e.strobe)
                    else flag_mismatch("mem_write_o.strobe", 32'(mem_write_o.strobe),
                                       32'(e.strobe));
            end
        end
    end : write_monitor

    // An open request keeps its payload until the acknowledge
    write_stable : assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_o && !mem_ack_i) |=> $stable(mem_write_o))
        else begin
            error_count++;
            $display("mem_write_o changed while the request was still open");
        end

    // ========================================
    // Test sequence
    // ========================================

    initial begin : stimulus
        int unsigned  cycles;
        int unsigned  start_writes;
        store_width_t w;
        data_word_t   addr;
        store_valid_i = 1'b0;
        store_req_i   = '0;
        commit_i      = 1'b0;
        flush_i       = 1'b0;
        fwd_addr_i    = '0;
        cycles        = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) fail_run("Reset was never released");
        end
        @(negedge clk);

        // Reset values
        assert (!mem_req_o) else flag_mismatch("mem_req_o", 32'(mem_req_o), 32'h0);
        assert (!store_full_o) else flag_mismatch("store_full_o", 32'(store_full_o), 32'h0);
        assert (!fwd_hit_o) else flag_mismatch("fwd_hit_o", 32'(fwd_hit_o), 32'h0);

        // Random stores over eight words, so merges happen now and then
        ack_en = 1'b1;
        for (int i = 0; i < 60; i++) begin
            case (take_bits(2))
                2'd0: w = STORE_BYTE;
                2'd1: w = STORE_HALF;
                default: w = STORE_WORD;
            endcase
            addr = 32'h200 + {take_bits(3), 2'b00};
            if (w == STORE_BYTE) addr[1:0] = take_bits(2);
            if (w == STORE_HALF) addr[1] = take_bits(1);
            do_store(make_req(addr, take_bits(32), w));
            if (take_bits(1) || (model_q.size() - n_cmt) >= 2) do_commit();
            check_forward(32'h200 + {take_bits(3), 2'b00});
        end
        while (model_q.size() > n_cmt) do_commit();
        wait_drained();

        // Two stores to one word merge into a single entry and a single write
        start_writes = write_count;
        do_store(make_req(32'h301, 32'h0000_00ab, STORE_BYTE));
        do_store(make_req(32'h302, 32'h0000_cdef, STORE_HALF));
        check_forward(32'h300);
        do_commit();
        wait_drained();
        assert (write_count == start_writes + 1)
            else flag_mismatch("write count", write_count - start_writes, 32'h1);

        // Flush keeps the committed store and drops the rest
        ack_en = 1'b0;
        start_writes = write_count;
        do_store(make_req(32'h500, 32'h1111_2222, STORE_WORD));
        do_commit();
        do_store(make_req(32'h504, 32'h3333_4444, STORE_WORD));
        do_store(make_req(32'h509, 32'h0000_0055, STORE_BYTE));
        flush_with_store(make_req(32'h50c, 32'h6666_7777, STORE_WORD));
        for (int a = 0; a < 4; a++) check_forward(32'h500 + 4 * a);
        ack_en = 1'b1;
        wait_drained();
        assert (write_count == start_writes + 1)
            else flag_mismatch("write count", write_count - start_writes, 32'h1);

        // With no acknowledge the buffer fills with committed stores
        ack_en = 1'b0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            assert (!store_full_o) else flag_mismatch("store_full_o", 32'(store_full_o), 32'h0);
            do_store(make_req(32'h400 + 4 * i, take_bits(32), STORE_WORD));
            do_commit();
        end
        assert (store_full_o) else flag_mismatch("store_full_o", 32'(store_full_o), 32'h1);
        ack_en = 1'b1;
        wait_drained();
        assert (!store_full_o) else flag_mismatch("store_full_o", 32'(store_full_o), 32'h0);
        end_run();
    end : stimulus

endmodule : store_path_tb

// ==== store_path_top.sv ====
`timescale 1ns/10ps

module store_path_top import lsu_pkg::*; #(
    parameter int unsigned SB_DEPTH = DEFAULT_SB_DEPTH
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       store_valid_i,
    input  store_req_t store_req_i,
    output logic       store_full_o,
    input  logic       commit_i,
    input  logic       flush_i,
    input  data_word_t fwd_addr_i,
    output logic       fwd_hit_o,
    output data_word_t fwd_data_o,
    output logic [3:0] fwd_strobe_o,
    output logic       mem_req_o,
    output mem_write_t mem_write_o,
    input  logic       mem_ack_i
);

    // Format stage to buffer
    logic         push;
    store_entry_t entry;

    // Buffer to drain stage and the pop returned by it
    logic         head_valid;
    store_entry_t head_entry;
    logic         pop;

    // Aligns the store data and builds the byte strobe
    store_format u_format (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .store_valid_i (store_valid_i),
        .store_req_i   (store_req_i),
        .push_o        (push),
        .entry_o       (entry)
    );

    // Holds the stores until commit and forwards to loads
    store_buffer #(
        .SB_DEPTH (SB_DEPTH)
    ) u_buffer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .push_i       (push),
        .entry_i      (entry),
        .commit_i     (commit_i),
        .pop_i        (pop),
        .full_o       (store_full_o),
        .head_valid_o (head_valid),
        .head_entry_o (head_entry),
        .fwd_addr_i   (fwd_addr_i),
        .fwd_hit_o    (fwd_hit_o),
        .fwd_data_o   (fwd_data_o),
        .fwd_strobe_o (fwd_strobe_o)
    );

    // Writes committed entries to memory one at a time
    store_drain u_drain (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .head_valid_i (head_valid),
        .head_entry_i (head_entry),
        .mem_ack_i    (mem_ack_i),
        .pop_o        (pop),
        .mem_req_o    (mem_req_o),
        .mem_write_o  (mem_write_o)
    );

endmodule : store_path_top

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 20,
    parameter int unsigned RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Free running clock with an even duty cycle
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset is held for a fixed number of rising edges and released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen
